// File: design/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl #(
    parameter int  num_sets     = 128,
    localparam int index_w      = $clog2(num_sets),
    localparam int stored_tag_w = cache_geom_pkg::tag_w + cache_geom_pkg::index_w_max - index_w
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              valid,
    input  wire                              op,       // 1 is a store.
    input  wire cache_geom_pkg::cache_addr_u addr,
    input  wire                              fence,
    input  wire                              hit,
    input  wire                              hit_way,
    input  wire                              victim_way,
    input  wire                              victim_dirty_valid,
    input  wire [stored_tag_w-1:0]           victim_tag,
    input  wire                              slot_dirty_valid,
    input  wire                              rd_ready,
    input  wire                              rd_valid,
    input  wire                              wr_ready,
    input  wire mem_port_pkg::line_t         wb_line,
    output logic                             ok,
    output logic                             rd_req,
    output logic [63:0]                      rd_addr,
    output logic                             wr_req,
    output logic [63:0]                      wr_addr,
    output mem_port_pkg::line_t              wr_data,
    output logic [index_w-1:0]               index,
    output logic [stored_tag_w-1:0]          tag,
    output logic                             fill_en,
    output logic                             fill_way,
    output logic                             fill_err,
    output logic                             store_en,
    output logic                             load_en,
    output logic                             touch_en,
    output logic                             clean_en,
    output logic [index_w:0]                 clean_slot,
    output logic                             way,
    output logic                             word_sel
);

    localparam logic [index_w:0] last_slot = '1;

    mem_port_pkg::ctrl_state_e state_q;
    mem_port_pkg::ctrl_state_e state_d;
    logic [index_w:0]          flush_cnt;
    logic                      armed;      // low for the first cycle after reset.
    logic                      miss;
    logic                      rd_xfer;
    logic                      wr_xfer;
    logic                      flush_step;
    logic [index_w-1:0]        wb_index;

    assign index    = addr.fields.index[index_w-1:0];
    assign tag      = addr.flat[63 -: stored_tag_w];
    assign word_sel = addr.fields.word_sel;

    assign ok   = hit && (state_q == mem_port_pkg::st_idle);
    assign miss = armed && valid && !hit && (state_q == mem_port_pkg::st_idle);

    // a miss raises its request in the same cycle it is seen.
    assign rd_req = armed && ((state_q == mem_port_pkg::st_refill) ||
                              (miss && !victim_dirty_valid));
    assign wr_req = armed && ((state_q == mem_port_pkg::st_writeback) ||
                              (miss && victim_dirty_valid) ||
                              (state_q == mem_port_pkg::st_fence && slot_dirty_valid));

    assign rd_xfer    = rd_req && rd_ready;
    assign wr_xfer    = wr_req && wr_ready;
    assign flush_step = (state_q == mem_port_pkg::st_fence) && (wr_xfer || !slot_dirty_valid);

    assign clean_slot = (state_q == mem_port_pkg::st_fence) ? flush_cnt : {index, victim_way};
    assign wb_index   = clean_slot[index_w:1];

    assign rd_addr = {addr.flat[63:cache_geom_pkg::offset_w], {cache_geom_pkg::offset_w{1'b0}}};
    assign wr_addr = {victim_tag, wb_index, {cache_geom_pkg::offset_w{1'b0}}};
    assign wr_data = wb_line;

    assign fill_en  = rd_xfer;
    assign fill_way = victim_way;
    assign fill_err = !rd_valid;   // the line is kept but flagged.
    assign clean_en = wr_xfer;
    assign store_en = valid && ok && op;
    assign load_en  = valid && ok && !op;
    assign touch_en = valid && ok;
    assign way      = hit ? hit_way : victim_way;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_port_pkg::st_idle: begin
                if (fence) begin
                    state_d = mem_port_pkg::st_fence;
                end else if (miss && victim_dirty_valid) begin
                    state_d = wr_xfer ? mem_port_pkg::st_refill : mem_port_pkg::st_writeback;
                end else if (miss && !rd_xfer) begin
                    state_d = mem_port_pkg::st_refill;
                end
            end
            mem_port_pkg::st_writeback: begin
                if (wr_xfer) begin
                    state_d = mem_port_pkg::st_refill;
                end
            end
            mem_port_pkg::st_refill: begin
                if (rd_xfer) begin
                    state_d = mem_port_pkg::st_idle;
                end
            end
            default: begin
                if (flush_step && flush_cnt == last_slot) begin
                    state_d = mem_port_pkg::st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= mem_port_pkg::st_idle;
            flush_cnt <= '0;
            armed     <= 1'b0;
        end else begin
            state_q <= state_d;
            armed   <= 1'b1;
            if (state_q != mem_port_pkg::st_fence) begin
                flush_cnt <= '0;
            end else if (flush_step) begin
                flush_cnt <= flush_cnt + 1'b1;   // wraps to zero as the walk ends.
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module cache_data_array #(
    parameter int  num_sets = 128,
    localparam int index_w  = $clog2(num_sets)
) (
    input  wire                              clk,
    input  wire [index_w-1:0]                index,
    input  wire                              way,
    input  wire                              word_sel,
    input  wire [mem_port_pkg::strb_w-1:0]   wstrb,
    input  wire [mem_port_pkg::word_w-1:0]   wdata,
    input  wire                              store_en,
    input  wire                              load_en,
    input  wire                              fill_en,
    input  wire mem_port_pkg::line_t         fill_line,
    input  wire [index_w:0]                  slot,
    input  wire                              line_err,
    output logic [mem_port_pkg::word_w-1:0]  rdata,
    output logic                             rw_error,
    output mem_port_pkg::line_t              wb_line
);

    mem_port_pkg::line_t line_mem [2*num_sets];
    mem_port_pkg::line_t cur_line;
    mem_port_pkg::line_t merged_line;
    logic [index_w:0]    acc_slot;

    assign acc_slot = {index, way};
    assign cur_line = line_mem[acc_slot];
    assign wb_line  = line_mem[slot];

    // only the strobed bytes of the addressed half change.
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < mem_port_pkg::strb_w; b++) begin
            if (wstrb[b]) begin
                merged_line[int'(word_sel) * mem_port_pkg::word_w + 8 * b +: 8] =
                    wdata[8 * b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_mem[acc_slot] <= fill_line;
        end else if (store_en) begin
            line_mem[acc_slot] <= merged_line;
        end
    end

    // load data and its error flag hold until the next load.
    always_ff @(posedge clk) begin
        if (load_en) begin
            rdata    <= word_sel ? cur_line[mem_port_pkg::line_w-1:mem_port_pkg::word_w]
                                 : cur_line[mem_port_pkg::word_w-1:0];
            rw_error <= line_err;
        end
    end

endmodule

`default_nettype wire

// File: design/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int offset_w    = 4;   // 16-byte lines.
    localparam int index_w_max = 7;   // up to 128 sets.
    localparam int tag_w       = 64 - index_w_max - offset_w;

    // the CPU address. The flat view goes to memory and the field view
    // drives the lookup.
    typedef union packed {
        logic [63:0] flat;
        struct packed {
            logic [tag_w-1:0]       tag;
            logic [index_w_max-1:0] index;
            logic                   word_sel;   // selects the upper 64-bit half.
            logic [2:0]             byte_off;
        } fields;
    } cache_addr_u;

endpackage

`default_nettype wire

// File: design/cache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module cache_tag_array #(
    parameter int  num_sets     = 128,
    localparam int index_w      = $clog2(num_sets),
    localparam int stored_tag_w = cache_geom_pkg::tag_w + cache_geom_pkg::index_w_max - index_w
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [index_w-1:0]       index,
    input  wire [stored_tag_w-1:0]  tag,
    input  wire                     fill_en,
    input  wire                     fill_way,
    input  wire                     fill_err,
    input  wire                     store_en,
    input  wire                     clean_en,
    input  wire [index_w:0]         clean_slot,
    input  wire                     touch_en,
    output logic                    hit,
    output logic                    hit_way,
    output logic                    victim_way,
    output logic                    victim_dirty_valid,
    output logic [stored_tag_w-1:0] victim_tag,
    output logic                    slot_dirty_valid,
    output logic                    line_err
);

    // a slot is {set index, way}.
    logic [stored_tag_w-1:0] tag_mem [2*num_sets];
    logic [2*num_sets-1:0]   valid_q;
    logic [2*num_sets-1:0]   dirty_q;
    logic [2*num_sets-1:0]   err_q;
    logic [num_sets-1:0]     mru_q;     // the way used last in each set.

    logic [index_w:0] slot0;
    logic [index_w:0] slot1;
    logic [index_w:0] hit_slot;
    logic [index_w:0] victim_slot;
    logic [index_w:0] fill_slot;
    logic             v0;
    logic             v1;
    logic             d0;
    logic             d1;
    logic             hit0;
    logic             hit1;

    assign slot0 = {index, 1'b0};
    assign slot1 = {index, 1'b1};
    assign v0    = valid_q[slot0];
    assign v1    = valid_q[slot1];
    assign d0    = dirty_q[slot0];
    assign d1    = dirty_q[slot1];

    assign hit0     = v0 && (tag_mem[slot0] == tag);
    assign hit1     = v1 && (tag_mem[slot1] == tag);
    assign hit      = hit0 || hit1;
    assign hit_way  = hit1;
    assign hit_slot = {index, hit_way};
    assign line_err = err_q[hit_slot];

    always_comb begin
        if (!v0 || !v1) begin
            victim_way = v0;            // the first invalid way.
        end else if (d0 != d1) begin
            victim_way = d0;            // the clean one saves a write-back.
        end else begin
            victim_way = !mru_q[index];
        end
    end

    assign victim_slot        = {index, victim_way};
    assign victim_dirty_valid = valid_q[victim_slot] && dirty_q[victim_slot];

    // clean_slot names either the victim of a miss or the slot of the flush walk.
    assign slot_dirty_valid = valid_q[clean_slot] && dirty_q[clean_slot];
    assign victim_tag       = tag_mem[clean_slot];

    assign fill_slot = {index, fill_way};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            mru_q   <= '0;
        end else begin
            if (fill_en) begin
                valid_q[fill_slot] <= 1'b1;
            end
            if (touch_en) begin
                mru_q[index] <= hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_slot] <= tag;
            err_q[fill_slot]   <= fill_err;   // kept until the line is replaced.
        end
        if (fill_en) begin
            dirty_q[fill_slot] <= 1'b0;
        end else if (store_en) begin
            dirty_q[hit_slot] <= 1'b1;
        end else if (clean_en) begin
            dirty_q[clean_slot] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
    parameter int num_sets = 128
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              valid,
    input  wire                              op,
    input  wire cache_geom_pkg::cache_addr_u addr,
    input  wire [mem_port_pkg::strb_w-1:0]   wstrb,
    input  wire [mem_port_pkg::word_w-1:0]   wdata,
    input  wire                              fence,
    output wire                              ok,
    output wire [mem_port_pkg::word_w-1:0]   rdata,
    output wire                              rw_error,
    output wire                              rd_req,
    output wire [63:0]                       rd_addr,
    input  wire                              rd_ready,
    input  wire                              rd_valid,
    input  wire mem_port_pkg::line_t         rd_data,
    output wire                              wr_req,
    output wire [63:0]                       wr_addr,
    output wire mem_port_pkg::line_t         wr_data,
    input  wire                              wr_ready
);

    localparam int index_w      = $clog2(num_sets);
    localparam int stored_tag_w = cache_geom_pkg::tag_w + cache_geom_pkg::index_w_max - index_w;

    logic [index_w-1:0]      index;
    logic [stored_tag_w-1:0] tag;
    logic                    hit;
    logic                    hit_way;
    logic                    victim_way;
    logic                    victim_dirty_valid;
    logic [stored_tag_w-1:0] victim_tag;
    logic                    slot_dirty_valid;
    logic                    line_err;
    logic                    fill_en;
    logic                    fill_way;
    logic                    fill_err;
    logic                    store_en;
    logic                    load_en;
    logic                    touch_en;
    logic                    clean_en;
    logic [index_w:0]        clean_slot;
    logic                    way;
    logic                    word_sel;
    mem_port_pkg::line_t     wb_line;

    cache_ctrl #(.num_sets(num_sets)) u_ctrl (
        .clk(clk), .rst(rst), .valid(valid), .op(op), .addr(addr), .fence(fence),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty_valid(victim_dirty_valid), .victim_tag(victim_tag),
        .slot_dirty_valid(slot_dirty_valid),
        .rd_ready(rd_ready), .rd_valid(rd_valid), .wr_ready(wr_ready), .wb_line(wb_line),
        .ok(ok), .rd_req(rd_req), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .index(index), .tag(tag), .fill_en(fill_en), .fill_way(fill_way), .fill_err(fill_err),
        .store_en(store_en), .load_en(load_en), .touch_en(touch_en),
        .clean_en(clean_en), .clean_slot(clean_slot), .way(way), .word_sel(word_sel)
    );

    cache_tag_array #(.num_sets(num_sets)) u_tags (
        .clk(clk), .rst(rst), .index(index), .tag(tag),
        .fill_en(fill_en), .fill_way(fill_way), .fill_err(fill_err),
        .store_en(store_en), .clean_en(clean_en), .clean_slot(clean_slot), .touch_en(touch_en),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty_valid(victim_dirty_valid), .victim_tag(victim_tag),
        .slot_dirty_valid(slot_dirty_valid), .line_err(line_err)
    );

    // refill data goes straight from the memory port into the line storage.
    cache_data_array #(.num_sets(num_sets)) u_data (
        .clk(clk), .index(index), .way(way), .word_sel(word_sel),
        .wstrb(wstrb), .wdata(wdata),
        .store_en(store_en), .load_en(load_en), .fill_en(fill_en), .fill_line(rd_data),
        .slot(clean_slot), .line_err(line_err),
        .rdata(rdata), .rw_error(rw_error), .wb_line(wb_line)
    );

endmodule

`default_nettype wire

// File: design/mem_port_pkg.sv
`default_nettype none

package mem_port_pkg;

    localparam int line_w = 128;
    localparam int word_w = 64;
    localparam int strb_w = word_w / 8;

    typedef logic [line_w-1:0] line_t;

    // the controller is either free for hits, or busy with one memory job.
    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_refill    = 2'b01,
        st_writeback = 2'b10,
        st_fence     = 2'b11
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: flist.f
design/cache_geom_pkg.sv
design/mem_port_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_ctrl.sv
design/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// File: verification/dcache_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_mem_model #(
    parameter int max_delay = 6,
    parameter int seed      = 1
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rd_req,
    input  wire [63:0]               rd_addr,
    output logic                     rd_ready,
    output logic                     rd_valid,
    output mem_port_pkg::line_t      rd_data,
    input  wire                      wr_req,
    input  wire [63:0]               wr_addr,
    input  wire mem_port_pkg::line_t wr_data,
    output logic                     wr_ready
);

    // 32 lines cover tags 0..7 over sets 0..3.
    mem_port_pkg::line_t mem [32];
    logic [31:0]         rng;
    int                  rd_wait;
    int                  wr_wait;
    logic                rd_active;
    logic                wr_active;
    int                  wb_count;

    function automatic logic [4:0] line_slot(input logic [63:0] a);
        return {a[13:11], a[5:4]};
    endfunction

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // every bit of the line address shapes the initial content.
    function automatic mem_port_pkg::line_t line_pattern(input logic [63:0] a);
        return {a * 64'h9e37_79b9_7f4a_7c15, a ^ 64'h5555_aaaa_0f0f_f0f0};
    endfunction

    initial begin
        rng       = seed;
        rd_ready  = 1'b0;
        rd_valid  = 1'b0;
        rd_data   = '0;
        wr_ready  = 1'b0;
        rd_active = 1'b0;
        wr_active = 1'b0;
        rd_wait   = 0;
        wr_wait   = 0;
        wb_count  = 0;
        for (int i = 0; i < 32; i++) begin
            mem[i] = line_pattern((64'(i[4:2]) << 11) | (64'(i[1:0]) << 4));
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_active <= 1'b0;
            wr_active <= 1'b0;
        end else begin
            if (rd_req && rd_ready) begin
                rd_active <= 1'b0;
            end else if (rd_req && !rd_active) begin
                rng = lcg(rng);
                rd_active <= 1'b1;
                rd_wait   <= int'(rng[23:8]) % max_delay;
            end else if (rd_active && rd_wait > 0) begin
                rd_wait <= rd_wait - 1;
            end
            if (wr_req && wr_ready) begin
                wr_active <= 1'b0;
                mem[line_slot(wr_addr)] <= wr_data;
                wb_count <= wb_count + 1;
            end else if (wr_req && !wr_active) begin
                rng = lcg(rng);
                wr_active <= 1'b1;
                wr_wait   <= int'(rng[23:8]) % max_delay;
            end else if (wr_active && wr_wait > 0) begin
                wr_wait <= wr_wait - 1;
            end
        end
    end

    // tag 7 is the bus error region.
    always @(negedge clk) begin
        rd_ready <= rd_active && rd_wait == 0 && rd_req;
        rd_valid <= rd_addr[13:11] != 3'd7;
        rd_data  <= mem[line_slot(rd_addr)];
        wr_ready <= wr_active && wr_wait == 0 && wr_req;
    end

endmodule

`default_nettype wire

// File: verification/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

    localparam int max_delay    = 6;
    localparam int num_requests = 240;
    localparam int cycle_limit  = 20 * num_requests * max_delay;

    logic clk;
    logic rst;
    logic valid;
    logic op;
    logic [7:0]  wstrb;
    logic [63:0] wdata;
    logic fence;
    cache_geom_pkg::cache_addr_u addr;
    logic ok;
    logic [63:0] rdata;
    logic rw_error;
    logic rd_req;
    logic [63:0] rd_addr;
    logic rd_ready;
    logic rd_valid;
    mem_port_pkg::line_t rd_data;
    logic wr_req;
    logic [63:0] wr_addr;
    mem_port_pkg::line_t wr_data;
    logic wr_ready;

    mem_port_pkg::line_t ref_img [32];
    logic       rv [4][2];
    logic [2:0] rt [4][2];
    logic       mdirty [4][2];
    logic       mru [4];

    logic [31:0] seed;
    int          errors;
    int          cycles;
    logic        ok_seen;    // a request completed at the last edge.
    logic        ok_lvl;
    logic        first;
    logic        busy;
    logic        fencing;
    logic        exp_hit;
    logic        exp_dirty;
    logic [63:0] exp_rd_addr;
    logic        load_chk;
    logic [63:0] exp_word;
    logic        exp_err;
    logic        mem_chk;
    logic        mem_equal;
    mem_port_pkg::line_t mem_exp;
    mem_port_pkg::line_t mem_act;
    int          exp_wb_count;
    int          act_wb_count;
    logic [4:0]  wb_slot;

    dcache_top #(.num_sets(128)) u_dut (
        .clk(clk), .rst(rst), .valid(valid), .op(op), .addr(addr), .wstrb(wstrb),
        .wdata(wdata), .fence(fence), .ok(ok), .rdata(rdata), .rw_error(rw_error),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_ready(rd_ready), .rd_valid(rd_valid),
        .rd_data(rd_data), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_ready(wr_ready)
    );

    dcache_mem_model #(.max_delay(max_delay), .seed(44883)) u_mem (
        .clk(clk), .rst(rst), .rd_req(rd_req), .rd_addr(rd_addr), .rd_ready(rd_ready),
        .rd_valid(rd_valid), .rd_data(rd_data), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_data(wr_data), .wr_ready(wr_ready)
    );

    function automatic mem_port_pkg::line_t init_line(input logic [63:0] a);
        return {a * 64'h9e37_79b9_7f4a_7c15, a ^ 64'h5555_aaaa_0f0f_f0f0};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw(output logic [31:0] v);
        seed = lcg_next(seed);
        v    = seed;
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] e,
                                   input logic [127:0] a);
        errors++;
        $display("[ERROR] %s: expected %h, actual %h", name, e, a);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    assign wb_slot = {wr_addr[13:11], wr_addr[5:4]};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        ok_seen <= !rst && valid && ok;
        ok_lvl  <= !rst && ok;
        cycles  <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    a_load: assert property (@(posedge clk) disable iff (rst)
        load_chk |-> (rdata == exp_word && rw_error == exp_err))
        else report_mismatch("load", {exp_err, exp_word}, {$sampled(rw_error), $sampled(rdata)});
    a_hit: assert property (@(posedge clk) disable iff (rst)
        (first && exp_hit) |-> (ok && !rd_req && !wr_req))
        else report_mismatch("hit", 3'b100, {$sampled(ok), $sampled(rd_req), $sampled(wr_req)});
    a_clean_miss: assert property (@(posedge clk) disable iff (rst)
        (first && !exp_hit && !exp_dirty) |-> (!ok && rd_req && !wr_req))
        else report_mismatch("clean miss", 3'b010,
                             {$sampled(ok), $sampled(rd_req), $sampled(wr_req)});
    a_dirty_miss: assert property (@(posedge clk) disable iff (rst)
        (first && !exp_hit && exp_dirty) |-> (!ok && !rd_req && wr_req))
        else report_mismatch("dirty miss", 3'b001,
                             {$sampled(ok), $sampled(rd_req), $sampled(wr_req)});
    a_no_wb: assert property (@(posedge clk) disable iff (rst)
        (busy && !exp_dirty) |-> !wr_req)
        else report_mismatch("victim clean", 1'b0, $sampled(wr_req));
    a_wb_addr: assert property (@(posedge clk) disable iff (rst)
        wr_req |-> (wr_addr[3:0] == 0 && wr_addr[10:6] == 0 && wr_addr[63:14] == 0))
        else report_mismatch("write-back address", 64'h0, $sampled(wr_addr) & ~64'h3830);
    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        (wr_req && wr_ready) |-> wr_data == ref_img[wb_slot])
        else report_mismatch("write-back data", ref_img[$sampled(wb_slot)], $sampled(wr_data));
    a_rd_addr: assert property (@(posedge clk) disable iff (rst)
        rd_req |-> (valid && rd_addr == exp_rd_addr))
        else report_mismatch("refill address", exp_rd_addr, $sampled(rd_addr));
    a_fence_rd: assert property (@(posedge clk) disable iff (rst)
        fencing |-> !rd_req)
        else report_mismatch("fence refill", 1'b0, $sampled(rd_req));
    a_mem_image: assert property (@(posedge clk) disable iff (rst)
        mem_chk |-> mem_equal)
        else report_mismatch("memory image", mem_exp, mem_act);
    a_fence_wb: assert property (@(posedge clk) disable iff (rst)
        mem_chk |-> act_wb_count == exp_wb_count)
        else report_mismatch("fence write-back count", exp_wb_count, act_wb_count);

    // one CPU request, issued and finished on falling edges.
    task automatic issue(input logic is_store, input logic [2:0] t, input logic [1:0] s,
                         input logic ws, input logic [7:0] strb, input logic [63:0] data);
        logic       w;
        logic [4:0] sl;
        sl = {t, s};
        if (rv[s][0] && rt[s][0] == t) begin
            exp_hit = 1'b1;
            w       = 1'b0;
        end else if (rv[s][1] && rt[s][1] == t) begin
            exp_hit = 1'b1;
            w       = 1'b1;
        end else begin
            exp_hit = 1'b0;
            if (!rv[s][0]) w = 1'b0;
            else if (!rv[s][1]) w = 1'b1;
            else if (mdirty[s][0] != mdirty[s][1]) w = mdirty[s][0];   // keep the dirty one.
            else w = !mru[s];
        end
        exp_dirty   = !exp_hit && rv[s][w] && mdirty[s][w];
        exp_rd_addr = (64'(t) << 11) | (64'(s) << 4);
        valid       = 1'b1;
        op          = is_store;
        addr.flat   = (64'(t) << 11) | (64'(s) << 4) | (64'(ws) << 3);
        wstrb       = strb;
        wdata       = data;
        first       = 1'b1;
        busy        = 1'b1;
        do begin
            @(negedge clk);
            first    = 1'b0;
            load_chk = 1'b0;
        end while (!ok_seen);
        busy  = 1'b0;
        valid = 1'b0;
        if (!exp_hit) begin
            rv[s][w]     = 1'b1;
            rt[s][w]     = t;
            mdirty[s][w] = 1'b0;
        end
        mru[s] = w;
        if (is_store) begin
            mdirty[s][w] = 1'b1;
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) ref_img[sl][(ws ? 64 : 0) + 8 * b +: 8] = data[8 * b +: 8];
            end
        end else begin
            exp_word = ws ? ref_img[sl][127:64] : ref_img[sl][63:0];
            exp_err  = (t == 3'd7);
            load_chk = 1'b1;
        end
    endtask

    task automatic fence_and_check();
        int wb_base;
        @(negedge clk);
        load_chk     = 1'b0;
        exp_wb_count = 0;
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (rv[s][w] && mdirty[s][w]) exp_wb_count++;
            end
        end
        wb_base = u_mem.wb_count;
        fence   = 1'b1;
        @(negedge clk);
        fence   = 1'b0;
        fencing = 1'b1;
        @(negedge clk);
        do begin
            @(negedge clk);
        end while (!ok_lvl);   // addr still names a cached line.
        fencing      = 1'b0;
        act_wb_count = u_mem.wb_count - wb_base;
        mem_equal    = 1'b1;
        for (int i = 0; i < 32; i++) begin
            if (mem_equal && u_mem.mem[i] != ref_img[i]) begin
                mem_equal = 1'b0;
                mem_exp   = ref_img[i];
                mem_act   = u_mem.mem[i];
            end
        end
        for (int s = 0; s < 4; s++) begin
            mdirty[s][0] = 1'b0;
            mdirty[s][1] = 1'b0;
        end
        mem_chk = 1'b1;
        @(negedge clk);
        mem_chk = 1'b0;
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (rv[s][w]) issue(1'b0, rt[s][w], s[1:0], 1'b0, 8'h00, 64'h0);
            end
        end
    endtask

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [2:0]  t;
        seed = 32'd44883;
        errors = 0;
        cycles = 0;
        rst = 1'b1;
        valid = 1'b0;
        op = 1'b0;
        addr = '0;
        wstrb = '0;
        wdata = '0;
        fence = 1'b0;
        first = 1'b0;
        busy = 1'b0;
        fencing = 1'b0;
        exp_hit = 1'b0;
        exp_dirty = 1'b0;
        exp_rd_addr = '0;
        load_chk = 1'b0;
        mem_chk = 1'b0;
        mem_equal = 1'b1;
        exp_wb_count = 0;
        act_wb_count = 0;
        for (int i = 0; i < 32; i++) begin
            ref_img[i] = init_line((64'(i[4:2]) << 11) | (64'(i[1:0]) << 4));
        end
        for (int s = 0; s < 4; s++) begin
            rv[s][0] = 1'b0;
            rv[s][1] = 1'b0;
            mru[s]   = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        // with all lines clean C evicts B, and A still hits afterwards.
        issue(1'b0, 3'd1, 2'd3, 1'b0, 8'h00, 64'h0);
        issue(1'b0, 3'd2, 2'd3, 1'b1, 8'h00, 64'h0);
        issue(1'b0, 3'd1, 2'd3, 1'b0, 8'h00, 64'h0);
        issue(1'b0, 3'd3, 2'd3, 1'b0, 8'h00, 64'h0);
        issue(1'b0, 3'd1, 2'd3, 1'b1, 8'h00, 64'h0);
        // B is the only dirty line, so the clean A goes although it was used last.
        issue(1'b0, 3'd1, 2'd2, 1'b0, 8'h00, 64'h0);
        issue(1'b1, 3'd2, 2'd2, 1'b0, 8'h3c, 64'h1122_3344_5566_7788);
        issue(1'b0, 3'd1, 2'd2, 1'b0, 8'h00, 64'h0);
        issue(1'b0, 3'd3, 2'd2, 1'b0, 8'h00, 64'h0);
        issue(1'b0, 3'd2, 2'd2, 1'b0, 8'h00, 64'h0);
        issue(1'b0, 3'd1, 2'd2, 1'b1, 8'h00, 64'h0);
        issue(1'b0, 3'd7, 2'd1, 1'b0, 8'h00, 64'h0);   // bus error line.
        for (int n = 0; n < 200; n++) begin
            draw(r0);
            draw(r1);
            draw(r2);
            case (r0[17:16])
                2'd0: t = 3'd1;
                2'd1: t = 3'd2;
                2'd2: t = 3'd3;
                default: t = 3'd7;
            endcase
            issue(r0[20], t, r0[19:18], r0[21], r0[31:24], {r1, r2});
        end
        fence_and_check();
        @(negedge clk);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
